/* source/mem_defs.svh */
`default_nettype none

`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// Word width of the data path and the memory
`define DATA_W 32

// Memory size in words and the width of a word index
`define MEM_DEPTH_WORDS 256
`define MEM_INDEX_W 8

`endif

`default_nettype wire

/* source/lsu_pkg.sv */
`include "mem_defs.svh"
`default_nettype none

package lsu_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [`DATA_W-1:0] data_t;
  typedef logic [`DATA_W/8-1:0] strb_t;

  // Bits 1:0 size, bit 2 sign extend, bit 3 load
  typedef logic [3:0] mem_op_t;

  typedef enum logic [3:0] {
    st_idle,
    st_hold,
    st_setup,
    st_load_req,
    st_load_resp,
    st_store_req,
    st_store_addr,
    st_store_data,
    st_store_resp
  } lsu_state_t;

endpackage

`default_nettype wire

/* source/mem_bus_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface mem_bus_if;

  // Read address and read data
  lsu_pkg::addr_t araddr;
  logic arvalid;
  logic arready;
  lsu_pkg::data_t rdata;
  logic rvalid;
  logic rready;

  // Write address, write data and write response
  lsu_pkg::addr_t awaddr;
  logic awvalid;
  logic awready;
  lsu_pkg::data_t wdata;
  lsu_pkg::strb_t wstrb;
  logic wvalid;
  logic wready;
  logic bvalid;
  logic bready;

  modport master (
    output araddr, arvalid, rready,
    output awaddr, awvalid, wdata, wstrb, wvalid, bready,
    input arready, rdata, rvalid,
    input awready, wready, bvalid
  );

  modport slave (
    input araddr, arvalid, rready,
    input awaddr, awvalid, wdata, wstrb, wvalid, bready,
    output arready, rdata, rvalid,
    output awready, wready, bvalid
  );

endinterface

`default_nettype wire

/* source/load_store_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module load_store_unit (
  input wire logic clock,
  input wire logic reset,
  input wire logic flush,
  input wire logic in_valid,
  output logic in_ready,
  input lsu_pkg::mem_op_t op,
  input lsu_pkg::addr_t addr,
  input lsu_pkg::data_t wdata,
  output logic out_valid,
  input wire logic out_ready,
  output lsu_pkg::data_t rdata,
  mem_bus_if.master bus
);

  import lsu_pkg::*;

  lsu_state_t state;
  lsu_state_t state_next;
  logic accept;

  // Operation captured on the accept edge
  mem_op_t op_q;
  addr_t addr_q;
  data_t wdata_q;
  data_t load_val;

  logic [4:0] byte_shift;
  data_t load_shifted;
  data_t load_ext;
  strb_t size_mask;

  assign accept = in_valid & in_ready;
  assign in_ready = (state == st_idle) | ((state == st_hold) & out_ready);
  assign out_valid = state == st_hold;
  assign rdata = load_val;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      state <= state_next;
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      op_q <= op;
      addr_q <= addr;
      wdata_q <= wdata;
    end
    if ((state == st_load_resp) && bus.rvalid) begin
      load_val <= load_ext;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      st_idle: begin
        if (in_valid) state_next = st_setup;
      end
      st_hold: begin
        if (out_ready) state_next = in_valid ? st_setup : st_idle;
      end
      // A flush here cancels the operation before any bus request
      st_setup: begin
        if (flush) state_next = st_idle;
        else if (op_q[3]) state_next = st_load_req;
        else state_next = st_store_req;
      end
      st_load_req: begin
        if (bus.arready) state_next = st_load_resp;
      end
      st_load_resp: begin
        if (bus.rvalid) state_next = st_hold;
      end
      st_store_req: begin
        if (bus.awready && bus.wready) state_next = st_store_resp;
        else if (bus.awready) state_next = st_store_data;
        else if (bus.wready) state_next = st_store_addr;
      end
      st_store_addr: begin
        if (bus.awready) state_next = st_store_resp;
      end
      st_store_data: begin
        if (bus.wready) state_next = st_store_resp;
      end
      st_store_resp: begin
        if (bus.bvalid) state_next = st_hold;
      end
      default: state_next = st_idle;
    endcase
  end

  assign byte_shift = {addr_q[1:0], 3'b000};

  // Loaded word is moved down to bit 0 and then extended by size
  assign load_shifted = bus.rdata >> byte_shift;

  always_comb begin
    case (op_q[1:0])
      2'd0: load_ext = {{24{load_shifted[7] & op_q[2]}}, load_shifted[7:0]};
      2'd1: load_ext = {{16{load_shifted[15] & op_q[2]}}, load_shifted[15:0]};
      default: load_ext = load_shifted;
    endcase
  end

  always_comb begin
    case (op_q[1:0])
      2'd0: size_mask = 4'b0001;
      2'd1: size_mask = 4'b0011;
      2'd2: size_mask = 4'b1111;
      default: size_mask = 4'b0000;
    endcase
  end

  assign bus.arvalid = state == st_load_req;
  assign bus.araddr = addr_q;
  assign bus.rready = state == st_load_resp;

  assign bus.awvalid = (state == st_store_req) | (state == st_store_addr);
  assign bus.awaddr = addr_q;
  assign bus.wvalid = (state == st_store_req) | (state == st_store_data);
  assign bus.wdata = wdata_q << byte_shift;
  assign bus.wstrb = size_mask << addr_q[1:0];
  assign bus.bready = state == st_store_resp;

endmodule

`default_nettype wire

/* source/bus_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

module bus_arbiter (
  input wire logic clock,
  input wire logic reset,
  mem_bus_if.slave req_a,
  mem_bus_if.slave req_b,
  mem_bus_if.master mem
);

  logic busy;
  logic owner;
  logic last_owner;
  logic want_a;
  logic want_b;
  logic active;
  logic sel_b;
  logic gnt_a;
  logic gnt_b;
  logic done;

  assign want_a = req_a.arvalid | req_a.awvalid | req_a.wvalid;
  assign want_b = req_b.arvalid | req_b.awvalid | req_b.wvalid;

  // An open transaction keeps its owner, otherwise round robin decides
  always_comb begin
    if (busy) sel_b = owner;
    else if (want_a && want_b) sel_b = ~last_owner;
    else sel_b = want_b;
  end

  assign active = busy | want_a | want_b;
  assign gnt_a = active & ~sel_b;
  assign gnt_b = active & sel_b;

  assign done = (mem.rvalid & mem.rready) | (mem.bvalid & mem.bready);

  always_ff @(posedge clock) begin
    if (reset) begin
      busy <= 1'b0;
      owner <= 1'b0;
      last_owner <= 1'b0;
    end else if (active) begin
      busy <= ~done;
      owner <= sel_b;
      if (done) last_owner <= sel_b;
    end
  end

  assign mem.araddr = sel_b ? req_b.araddr : req_a.araddr;
  assign mem.arvalid = sel_b ? req_b.arvalid : req_a.arvalid;
  assign mem.rready = sel_b ? req_b.rready : req_a.rready;
  assign mem.awaddr = sel_b ? req_b.awaddr : req_a.awaddr;
  assign mem.awvalid = sel_b ? req_b.awvalid : req_a.awvalid;
  assign mem.wdata = sel_b ? req_b.wdata : req_a.wdata;
  assign mem.wstrb = sel_b ? req_b.wstrb : req_a.wstrb;
  assign mem.wvalid = sel_b ? req_b.wvalid : req_a.wvalid;
  assign mem.bready = sel_b ? req_b.bready : req_a.bready;

  assign req_a.arready = gnt_a & mem.arready;
  assign req_a.rvalid = gnt_a & mem.rvalid;
  assign req_a.rdata = mem.rdata;
  assign req_a.awready = gnt_a & mem.awready;
  assign req_a.wready = gnt_a & mem.wready;
  assign req_a.bvalid = gnt_a & mem.bvalid;

  assign req_b.arready = gnt_b & mem.arready;
  assign req_b.rvalid = gnt_b & mem.rvalid;
  assign req_b.rdata = mem.rdata;
  assign req_b.awready = gnt_b & mem.awready;
  assign req_b.wready = gnt_b & mem.wready;
  assign req_b.bvalid = gnt_b & mem.bvalid;

endmodule

`default_nettype wire

/* source/word_memory.sv */
`timescale 1ns/1ns
`include "mem_defs.svh"
`default_nettype none

module word_memory (
  input wire logic clock,
  input wire logic reset,
  mem_bus_if.slave bus
);

  import lsu_pkg::*;

  data_t mem_words [`MEM_DEPTH_WORDS];
  data_t rd_word;
  logic rd_pend;
  logic wr_pend;
  logic rd_fire;
  logic wr_fire;
  logic [`MEM_INDEX_W-1:0] rd_index;
  logic [`MEM_INDEX_W-1:0] wr_index;

  assign rd_index = bus.araddr[`MEM_INDEX_W+1:2];
  assign wr_index = bus.awaddr[`MEM_INDEX_W+1:2];

  assign rd_fire = bus.arvalid & ~rd_pend;
  // Address and data are taken together in one edge
  assign wr_fire = bus.awvalid & bus.wvalid & ~wr_pend;

  assign bus.arready = ~rd_pend;
  assign bus.rvalid = rd_pend;
  assign bus.rdata = rd_word;
  assign bus.awready = wr_fire;
  assign bus.wready = wr_fire;
  assign bus.bvalid = wr_pend;

  always_ff @(posedge clock) begin
    if (reset) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
    end else begin
      if (rd_fire) rd_pend <= 1'b1;
      else if (bus.rready) rd_pend <= 1'b0;
      if (wr_fire) wr_pend <= 1'b1;
      else if (bus.bready) wr_pend <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (rd_fire) rd_word <= mem_words[rd_index];
    if (wr_fire) begin
      for (int i = 0; i < `DATA_W / 8; i++) begin
        if (bus.wstrb[i]) mem_words[wr_index][i*8 +: 8] <= bus.wdata[i*8 +: 8];
      end
    end
  end

endmodule

`default_nettype wire

/* source/lsu_top.sv */
`timescale 1ns/1ns
`default_nettype none

module lsu_top (
  input wire logic clock,
  input wire logic reset,

  input wire logic in_valid_a,
  output logic in_ready_a,
  input lsu_pkg::mem_op_t op_a,
  input lsu_pkg::addr_t addr_a,
  input lsu_pkg::data_t wdata_a,
  input wire logic flush_a,
  output logic out_valid_a,
  input wire logic out_ready_a,
  output lsu_pkg::data_t rdata_a,

  input wire logic in_valid_b,
  output logic in_ready_b,
  input lsu_pkg::mem_op_t op_b,
  input lsu_pkg::addr_t addr_b,
  input lsu_pkg::data_t wdata_b,
  input wire logic flush_b,
  output logic out_valid_b,
  input wire logic out_ready_b,
  output lsu_pkg::data_t rdata_b
);

  mem_bus_if bus_a ();
  mem_bus_if bus_b ();
  mem_bus_if bus_mem ();

  load_store_unit unit_a (
    .clock(clock), .reset(reset), .flush(flush_a),
    .in_valid(in_valid_a), .in_ready(in_ready_a),
    .op(op_a), .addr(addr_a), .wdata(wdata_a),
    .out_valid(out_valid_a), .out_ready(out_ready_a), .rdata(rdata_a),
    .bus(bus_a.master)
  );

  load_store_unit unit_b (
    .clock(clock), .reset(reset), .flush(flush_b),
    .in_valid(in_valid_b), .in_ready(in_ready_b),
    .op(op_b), .addr(addr_b), .wdata(wdata_b),
    .out_valid(out_valid_b), .out_ready(out_ready_b), .rdata(rdata_b),
    .bus(bus_b.master)
  );

  bus_arbiter arbiter (
    .clock(clock), .reset(reset),
    .req_a(bus_a.slave), .req_b(bus_b.slave), .mem(bus_mem.master)
  );

  word_memory memory (
    .clock(clock), .reset(reset), .bus(bus_mem.slave)
  );

endmodule

`default_nettype wire

/* bench/lsu_top_chk.sv */
`timescale 1ns/1ns
`default_nettype none

module lsu_top_chk (
  input wire logic clock,
  input wire logic reset,
  input wire logic done,
  input wire logic gnt,
  input wire logic gnt_other,
  input wire logic ready,
  input wire logic arvalid,
  input wire logic arready,
  input lsu_pkg::addr_t araddr,
  input wire logic awvalid,
  input wire logic awready,
  input lsu_pkg::addr_t awaddr,
  input wire logic wvalid,
  input wire logic wready,
  input lsu_pkg::data_t wdata,
  input lsu_pkg::strb_t wstrb
);

  // The owner keeps the bus alone until its read data or write response
  assert property (@(posedge clock) disable iff (reset)
    gnt && !done |=> gnt && !gnt_other)
    else $error("Grant moved or doubled before the transaction closed");

  // A waiting unit keeps valid and payload until the transfer
  assert property (@(posedge clock) disable iff (reset)
    arvalid && !arready |=> arvalid && $stable(araddr))
    else $error("Read address dropped or changed before transfer");
  assert property (@(posedge clock) disable iff (reset)
    awvalid && !awready |=> awvalid && $stable(awaddr))
    else $error("Write address dropped or changed before transfer");
  assert property (@(posedge clock) disable iff (reset)
    wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb))
    else $error("Write data dropped or changed before transfer");

  assert property (@(posedge clock) disable iff (reset)
    gnt_other && !done |=> !ready)
    else $error("A unit saw a ready or valid while the other unit owned the bus");

endmodule

bind bus_arbiter lsu_top_chk chk_a (
  .clock(clock), .reset(reset), .done(done), .gnt(gnt_a), .gnt_other(gnt_b),
  .ready(req_a.arready | req_a.awready | req_a.wready | req_a.rvalid | req_a.bvalid),
  .arvalid(req_a.arvalid), .arready(req_a.arready), .araddr(req_a.araddr),
  .awvalid(req_a.awvalid), .awready(req_a.awready), .awaddr(req_a.awaddr),
  .wvalid(req_a.wvalid), .wready(req_a.wready), .wdata(req_a.wdata), .wstrb(req_a.wstrb)
);

bind bus_arbiter lsu_top_chk chk_b (
  .clock(clock), .reset(reset), .done(done), .gnt(gnt_b), .gnt_other(gnt_a),
  .ready(req_b.arready | req_b.awready | req_b.wready | req_b.rvalid | req_b.bvalid),
  .arvalid(req_b.arvalid), .arready(req_b.arready), .araddr(req_b.araddr),
  .awvalid(req_b.awvalid), .awready(req_b.awready), .awaddr(req_b.awaddr),
  .wvalid(req_b.wvalid), .wready(req_b.wready), .wdata(req_b.wdata), .wstrb(req_b.wstrb)
);

`default_nettype wire

/* bench/lsu_top_tb.sv */
`timescale 1ns/1ns
`include "mem_defs.svh"
`default_nettype none

module lsu_top_tb;

  import lsu_pkg::*;

  // Up to 728 operations per port, each far below 25 cycles with contention
  localparam int MAX_CYCLES = 20000;
  localparam int REGION_WORDS = `MEM_DEPTH_WORDS / 2;
  localparam int RANDOM_OPS = 300;

  logic clock = 1'b0;
  logic reset;
  logic [1:0] in_valid, in_ready, flush, out_valid, out_ready;
  mem_op_t op [2];
  addr_t addr [2];
  data_t wdata [2];
  data_t rdata [2];

  data_t model [`MEM_DEPTH_WORDS];
  integer seed;
  int cycles = 0;

  lsu_top DUT (
    .clock(clock), .reset(reset),
    .in_valid_a(in_valid[0]), .in_ready_a(in_ready[0]), .op_a(op[0]), .addr_a(addr[0]),
    .wdata_a(wdata[0]), .flush_a(flush[0]), .out_valid_a(out_valid[0]),
    .out_ready_a(out_ready[0]), .rdata_a(rdata[0]),
    .in_valid_b(in_valid[1]), .in_ready_b(in_ready[1]), .op_b(op[1]), .addr_b(addr[1]),
    .wdata_b(wdata[1]), .flush_b(flush[1]), .out_valid_b(out_valid[1]),
    .out_ready_b(out_ready[1]), .rdata_b(rdata[1])
  );

  always #5 clock = ~clock;

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("The run did not finish within %0d cycles", MAX_CYCLES);
      $display("Simulation finished: FAIL");
      $fatal(1, "Timeout");
    end
  end

  task automatic check_value(input string name, input data_t expected, input data_t actual);
    if (expected !== actual) begin
      $display("FAILED %s: expected %h, actual %h", name, expected, actual);
      $display("Simulation finished: FAIL");
      $fatal(1, "Mismatch in %s", name);
    end
  endtask

  function automatic strb_t strobe_of(input mem_op_t o, input logic [1:0] off);
    case (o[1:0])
      2'd0: return 4'b0001 << off;
      2'd1: return 4'b0011 << off;
      default: return 4'b1111;
    endcase
  endfunction

  // Byte offset moves the lane down to bit 0, then size and sign bit extend it
  function automatic data_t extract(input data_t word, input mem_op_t o, input logic [1:0] off);
    data_t v;
    v = word >> {off, 3'b000};
    case (o[1:0])
      2'd0: return o[2] ? {{24{v[7]}}, v[7:0]} : {24'd0, v[7:0]};
      2'd1: return o[2] ? {{16{v[15]}}, v[15:0]} : {16'd0, v[15:0]};
      default: return v;
    endcase
  endfunction

  task automatic apply_store(input addr_t a, input mem_op_t o, input data_t d);
    strb_t s;
    data_t lanes;
    s = strobe_of(o, a[1:0]);
    lanes = d << {a[1:0], 3'b000};
    for (int i = 0; i < 4; i++) begin
      if (s[i]) model[a[`MEM_INDEX_W+1:2]][i*8 +: 8] = lanes[i*8 +: 8];
    end
  endtask

  task automatic do_op(input int p, input mem_op_t o, input addr_t a, input data_t d,
                       input logic fl, input string name);
    data_t expected;
    data_t first;
    logic seen;
    logic done;
    expected = '0;
    first = '0;
    seen = 1'b0;
    done = 1'b0;
    in_valid[p] = 1'b1;
    op[p] = o;
    addr[p] = a;
    wdata[p] = d;
    while (!done) begin
      @(negedge clock);
      check_value({name, " duplicate result"}, 32'd0, 32'(out_valid[p]));
      done = in_ready[p];
      @(posedge clock);
      #1;
    end
    in_valid[p] = 1'b0;
    flush[p] = fl;
    if (o[3]) expected = extract(model[a[`MEM_INDEX_W+1:2]], o, a[1:0]);
    else if (!fl) apply_store(a, o, d);
    @(posedge clock);
    #1;
    flush[p] = 1'b0;
    if (fl) begin
      @(negedge clock);
      check_value({name, " flushed result"}, 32'd0, 32'(out_valid[p]));
      check_value({name, " ready after flush"}, 32'd1, 32'(in_ready[p]));
      @(posedge clock);
      #1;
      return;
    end
    done = 1'b0;
    while (!done) begin
      @(negedge clock);
      if (seen) check_value({name, " out_valid held"}, 32'd1, 32'(out_valid[p]));
      if (out_valid[p]) begin
        if (!seen) first = rdata[p];
        seen = 1'b1;
        if (o[3]) check_value({name, " stable rdata"}, first, rdata[p]);
        if (out_ready[p]) begin
          if (o[3]) check_value(name, expected, rdata[p]);
          done = 1'b1;
        end else begin
          check_value({name, " in_ready while stalled"}, 32'd0, 32'(in_ready[p]));
        end
      end
      @(posedge clock);
      #1;
      out_ready[p] = ($random(seed) & 3) != 0;
    end
  endtask

  task automatic run_port(input int p);
    integer r;
    int idx;
    mem_op_t o;
    addr_t a;
    logic fl;
    for (int i = 0; i < REGION_WORDS; i++) begin
      do_op(p, 4'b0010, addr_t'(p * REGION_WORDS + i) << 2, 32'd0, 1'b0, "init store");
    end
    for (int i = 0; i < RANDOM_OPS; i++) begin
      r = $random(seed);
      idx = p * REGION_WORDS + int'(r[15:0]) % REGION_WORDS;
      o[1:0] = (r[17:16] == 2'd3) ? 2'd2 : r[17:16];
      o[2] = r[18];
      o[3] = r[19];
      a = addr_t'(idx) << 2;
      if (o[1:0] == 2'd0) a[1:0] = r[21:20];
      else if (o[1:0] == 2'd1) a[1:0] = {r[21], 1'b0};
      fl = r[25:22] == 4'd0;
      do_op(p, o, a, $random(seed), fl, o[3] ? "random load" : "random store");
      // Read back the whole word after a flush and after some stores
      if (fl || (!o[3] && r[26])) begin
        do_op(p, 4'b1010, {a[31:2], 2'b00}, 32'd0, 1'b0, "word readback");
      end
    end
  endtask

  initial begin
    seed = 75145;
    reset = 1'b1;
    in_valid = '0;
    flush = '0;
    out_ready = '0;
    for (int p = 0; p < 2; p++) begin
      op[p] = '0;
      addr[p] = '0;
      wdata[p] = '0;
    end
    repeat (3) @(posedge clock);
    #1;
    reset = 1'b0;
    fork
      run_port(0);
      run_port(1);
    join
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
+incdir+source
source/lsu_pkg.sv
source/mem_bus_if.sv
source/load_store_unit.sv
source/bus_arbiter.sv
source/word_memory.sv
source/lsu_top.sv
bench/lsu_top_chk.sv
bench/lsu_top_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module lsu_top_tb -f project.f -o lsu_sim &&
./obj_dir/lsu_sim || exit 1
